//--- rtl/dmem_pkg.sv
// Shared widths, encodings and request/command structs for the four-bank data memory
// Imported by every module of the memory subsystem and by the testbench
package dmem_pkg;

	//////////////////////////////////////////////////
	// Widths and geometry
	//////////////////////////////////////////////////
	localparam int WORD_WIDTH     = 32;                     // Data word
	localparam int STRB_BITS      = WORD_WIDTH / 8;         // One strobe per byte lane
	localparam int NUM_BANKS      = 4;                      // Banks, also vector lanes
	localparam int BANK_SEL_BITS  = 2;                      // Word addr [1:0]
	localparam int ROW_BITS       = 8;                      // Row within a bank
	localparam int BANK_DEPTH     = 1 << ROW_BITS;          // 256 words per bank
	localparam int WORD_ADDR_BITS = ROW_BITS + BANK_SEL_BITS; // Row above bank bits
	localparam int BYTE_ADDR_BITS = WORD_ADDR_BITS + 2;     // Scalar byte address

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////
	// Store size, same codes as funct3 of SB/SH/SW
	typedef enum logic [1:0] {
		ST_BYTE = 2'd0,
		ST_HALF = 2'd1,
		ST_WORD = 2'd2
	} store_sel_e;

	// Load kind, funct3 codes
	typedef enum logic [2:0] {
		LD_B  = 3'b000,
		LD_H  = 3'b001,
		LD_W  = 3'b010,
		LD_BU = 3'b100,
		LD_HU = 3'b101
	} load_sel_e;

	// Owner of one bank in the current cycle
	typedef enum logic [1:0] {
		SRC_NONE   = 2'd0,
		SRC_SCALAR = 2'd1,
		SRC_VECTOR = 2'd2,
		SRC_CON    = 2'd3
	} source_e;

	// One word per lane / bank
	typedef logic [NUM_BANKS-1:0][WORD_WIDTH-1:0] lane_data_t;

	//////////////////////////////////////////////////
	// Peer requests
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                      valid;
		logic                      is_store;
		store_sel_e                store_sel;  // Only for stores
		load_sel_e                 load_sel;   // Only for loads
		logic [BYTE_ADDR_BITS-1:0] addr;
		logic [WORD_WIDTH-1:0]     wdata;      // Unaligned, low bits hold the value
	} scalar_req_t;

	typedef struct packed {
		logic                                valid;
		logic                                is_store;
		logic [NUM_BANKS-1:0][ROW_BITS-1:0] row;   // Lane i goes to bank i
		lane_data_t                          wdata;
	} vector_req_t;

	typedef struct packed {
		logic                      valid;
		logic [STRB_BITS-1:0]      strb;   // All zero means read
		logic [WORD_ADDR_BITS-1:0] addr;
		logic [WORD_WIDTH-1:0]     wdata;
	} con_req_t;

	// Per-bank command from the arbiter
	typedef struct packed {
		logic                 en;
		logic [STRB_BITS-1:0] strb;
		logic [ROW_BITS-1:0]  row;
		logic [WORD_WIDTH-1:0] wdata;
	} bank_cmd_t;

	typedef bank_cmd_t [NUM_BANKS-1:0] bank_cmd_arr_t;

	// Read owner, one cycle behind the access
	typedef struct packed {
		logic                     s_rd;    // Scalar load in flight
		logic                     c_rd;    // Controller read in flight
		logic                     v_rd;    // Vector load in flight
		logic [BANK_SEL_BITS-1:0] s_bank;
		logic [1:0]               offset;  // Scalar byte offset
		load_sel_e                load_sel;
		logic [BANK_SEL_BITS-1:0] c_bank;
	} rd_tag_t;

endpackage

//--- rtl/store_align.sv
// Scalar store alignment: splits the byte address and builds strobes and lane data
// Purely combinational, feeds the arbiter's scalar inputs
`timescale 1ns/1ps

module store_align (
	input  dmem_pkg::scalar_req_t                    req,
	output logic [dmem_pkg::BANK_SEL_BITS-1:0]      bank,
	output logic [dmem_pkg::ROW_BITS-1:0]           row,
	output logic [dmem_pkg::STRB_BITS-1:0]          strb,
	output logic [dmem_pkg::WORD_WIDTH-1:0]         wdata
);
	import dmem_pkg::*;

	logic [1:0] offset;    // Byte within the word

	// Byte address = {row, bank, offset}
	assign offset = req.addr[1:0];
	assign bank   = req.addr[BANK_SEL_BITS+1:2];
	assign row    = req.addr[BYTE_ADDR_BITS-1:BANK_SEL_BITS+2];

	always_comb begin
		strb  = '0;           // Loads write nothing
		wdata = req.wdata;
		if (req.is_store) begin
			case (req.store_sel)
				ST_BYTE: begin
					// One lane, byte copied everywhere
					strb  = STRB_BITS'(1) << offset;
					wdata = {4{req.wdata[7:0]}};
				end
				ST_HALF: begin
					// Bit 1 picks the half, bit 0 ignored
					strb  = offset[1] ? 4'b1100 : 4'b0011;
					wdata = {2{req.wdata[15:0]}};
				end
				ST_WORD: begin
					strb  = '1;       // Offset ignored
					wdata = req.wdata;
				end
				default: begin
					strb  = '0;       // Unused code, drop the write
					wdata = req.wdata;
				end
			endcase
		end
	end

endmodule

//--- rtl/mem_arbiter.sv
// Fixed-priority arbiter for the shared banks: scalar, then vector, then controller
// Builds one command per bank and registers the owner of each read for the load path
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                                   clk_buf,
	input  logic                                   arst_n,

	// Scalar peer, already aligned
	input  logic                                   s_valid,
	input  logic                                   s_is_store,
	input  logic [dmem_pkg::BANK_SEL_BITS-1:0]     s_bank,
	input  logic [dmem_pkg::ROW_BITS-1:0]          s_row,
	input  logic [1:0]                             s_offset,
	input  logic [dmem_pkg::STRB_BITS-1:0]         s_strb,
	input  logic [dmem_pkg::WORD_WIDTH-1:0]        s_wdata,
	input  dmem_pkg::load_sel_e                    s_load_sel,

	// Vector and controller peers
	input  dmem_pkg::vector_req_t                  vreq,
	input  dmem_pkg::con_req_t                     creq,
	output logic                                   vec_gnt,
	output logic                                   con_gnt,

	// Toward banks and load path
	output dmem_pkg::bank_cmd_arr_t                cmd,
	output dmem_pkg::rd_tag_t                      tag
);
	import dmem_pkg::*;

	logic [BANK_SEL_BITS-1:0] c_bank;          // Controller word addr [1:0]
	logic [ROW_BITS-1:0]      c_row;
	source_e                  owner [NUM_BANKS]; // Who drives each bank
	rd_tag_t                  tag_d;
	logic                     any_rd;

	assign c_bank = creq.addr[BANK_SEL_BITS-1:0];
	assign c_row  = creq.addr[WORD_ADDR_BITS-1:BANK_SEL_BITS];

	//////////////////////////////////////////////////
	// Grants
	//////////////////////////////////////////////////
	// Vector needs every bank, so any scalar blocks it
	assign vec_gnt = vreq.valid && !s_valid;
	// Controller loses to vector and to a scalar on its bank
	assign con_gnt = creq.valid && !vec_gnt && !(s_valid && (s_bank == c_bank));

	// Bank ownership
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (vec_gnt)
				owner[b] = SRC_VECTOR;
			else if (s_valid && (s_bank == BANK_SEL_BITS'(b)))
				owner[b] = SRC_SCALAR;   // Scalar never waits
			else if (con_gnt && (c_bank == BANK_SEL_BITS'(b)))
				owner[b] = SRC_CON;
			else
				owner[b] = SRC_NONE;
		end
	end

	//////////////////////////////////////////////////
	// Per-bank commands
	//////////////////////////////////////////////////
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			cmd[b] = '0;
			case (owner[b])
				SRC_SCALAR: begin
					cmd[b].en    = 1'b1;
					cmd[b].strb  = s_strb;       // Zero on a load
					cmd[b].row   = s_row;
					cmd[b].wdata = s_wdata;
				end
				SRC_VECTOR: begin
					cmd[b].en    = 1'b1;
					cmd[b].strb  = vreq.is_store ? '1 : '0;  // Full words only
					cmd[b].row   = vreq.row[b];  // Lane b on bank b
					cmd[b].wdata = vreq.wdata[b];
				end
				SRC_CON: begin
					cmd[b].en    = 1'b1;
					cmd[b].strb  = creq.strb;
					cmd[b].row   = c_row;
					cmd[b].wdata = creq.wdata;
				end
				default: cmd[b] = '0;        // Idle bank
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read tag, one cycle of latency
	//////////////////////////////////////////////////
	always_comb begin
		tag_d          = '0;
		tag_d.s_rd     = s_valid && !s_is_store;
		tag_d.c_rd     = con_gnt && (creq.strb == '0);
		tag_d.v_rd     = vec_gnt && !vreq.is_store;
		tag_d.s_bank   = s_bank;
		tag_d.offset   = s_offset;
		tag_d.load_sel = s_load_sel;
		tag_d.c_bank   = c_bank;      // Scalar and controller may both read
	end

	assign any_rd = tag_d.s_rd || tag_d.c_rd || tag_d.v_rd;

	always_ff @(posedge clk_buf or negedge arst_n) begin
		if (!arst_n)
			tag <= '0;                  // No owner after reset
		else
			tag <= any_rd ? tag_d : '0; // Cleared on cycles without a read
	end

endmodule

//--- rtl/bank_array.sv
// Four word-interleaved data banks with byte strobes and registered read data
// Each bank reads its commanded row whenever its command is enabled
`timescale 1ns/1ps

module bank_array (
	input  logic                        clk_buf,
	input  dmem_pkg::bank_cmd_arr_t     cmd,
	output dmem_pkg::lane_data_t        rdata
);
	import dmem_pkg::*;

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic [WORD_WIDTH-1:0] mem [BANK_DEPTH];  // Block RAM, no reset
		logic [WORD_WIDTH-1:0] rd_q;              // Read register

		always_ff @(posedge clk_buf) begin
			if (cmd[b].en) begin
				// Byte-lane writes
				for (int i = 0; i < STRB_BITS; i++) begin
					if (cmd[b].strb[i])
						mem[cmd[b].row][i*8 +: 8] <= cmd[b].wdata[i*8 +: 8];
				end
				rd_q <= mem[cmd[b].row];  // Old data on same-row write
			end
		end

		assign rdata[b] = rd_q;
	end

endmodule

//--- rtl/load_align.sv
// Load path: picks the scalar bank word, extracts and extends the addressed data
// Also routes raw words to the controller and vector peers, valids from the read tag
`timescale 1ns/1ps

module load_align (
	input  dmem_pkg::rd_tag_t                tag,
	input  dmem_pkg::lane_data_t             rdata,
	output logic [dmem_pkg::WORD_WIDTH-1:0]  scalar_rdata,
	output logic                             scalar_rvalid,
	output dmem_pkg::lane_data_t             vec_rdata,
	output logic                             vec_rvalid,
	output logic [dmem_pkg::WORD_WIDTH-1:0]  con_rdata,
	output logic                             con_rvalid
);
	import dmem_pkg::*;

	logic [WORD_WIDTH-1:0] s_word;   // Scalar bank word
	logic [7:0]            s_byte;
	logic [15:0]           s_half;

	assign s_word = rdata[tag.s_bank];
	assign s_byte = s_word[{tag.offset, 3'b000} +: 8];
	assign s_half = tag.offset[1] ? s_word[31:16] : s_word[15:0];  // Bit 0 ignored

	// Extension by funct3
	always_comb begin
		case (tag.load_sel)
			LD_B:    scalar_rdata = {{(WORD_WIDTH-8){s_byte[7]}}, s_byte};
			LD_BU:   scalar_rdata = {{(WORD_WIDTH-8){1'b0}}, s_byte};
			LD_H:    scalar_rdata = {{(WORD_WIDTH-16){s_half[15]}}, s_half};
			LD_HU:   scalar_rdata = {{(WORD_WIDTH-16){1'b0}}, s_half};
			LD_W:    scalar_rdata = s_word;   // Offset ignored
			default: scalar_rdata = s_word;
		endcase
	end

	//////////////////////////////////////////////////
	// Raw routes and valids
	//////////////////////////////////////////////////
	assign con_rdata     = rdata[tag.c_bank];
	assign vec_rdata     = rdata;           // Lane i from bank i
	assign scalar_rvalid = tag.s_rd;
	assign con_rvalid    = tag.c_rd;
	assign vec_rvalid    = tag.v_rd;

endmodule

//--- rtl/dmem_top.sv
// Top of the shared data memory: scalar, vector and controller peers on four banks
// Reads return one cycle after acceptance; vector and controller wait on their grants
`timescale 1ns/1ps

module dmem_top (
	input  logic                                clk_buf,
	input  logic                                arst_n,

	// Peer requests
	input  dmem_pkg::scalar_req_t               sreq,
	input  dmem_pkg::vector_req_t               vreq,
	input  dmem_pkg::con_req_t                  creq,

	// Grants
	output logic                                vec_gnt,
	output logic                                con_gnt,

	// Read returns
	output logic [dmem_pkg::WORD_WIDTH-1:0]     scalar_rdata,
	output logic                                scalar_rvalid,
	output dmem_pkg::lane_data_t                vec_rdata,
	output logic                                vec_rvalid,
	output logic [dmem_pkg::WORD_WIDTH-1:0]     con_rdata,
	output logic                                con_rvalid
);
	import dmem_pkg::*;

	logic [BANK_SEL_BITS-1:0] st_bank;    // Aligned scalar access
	logic [ROW_BITS-1:0]      st_row;
	logic [STRB_BITS-1:0]     st_strb;
	logic [WORD_WIDTH-1:0]    st_wdata;
	bank_cmd_arr_t            cmd;
	rd_tag_t                  tag;
	lane_data_t               bank_rdata; // Registered bank outputs

	//////////////////////////////////////////////////
	// Store side
	//////////////////////////////////////////////////
	store_align u_store_align (
		.req   (sreq),
		.bank  (st_bank),
		.row   (st_row),
		.strb  (st_strb),
		.wdata (st_wdata)
	);

	mem_arbiter u_mem_arbiter (
		.clk_buf    (clk_buf),
		.arst_n     (arst_n),
		.s_valid    (sreq.valid),
		.s_is_store (sreq.is_store),
		.s_bank     (st_bank),
		.s_row      (st_row),
		.s_offset   (sreq.addr[1:0]),
		.s_strb     (st_strb),
		.s_wdata    (st_wdata),
		.s_load_sel (sreq.load_sel),
		.vreq       (vreq),
		.creq       (creq),
		.vec_gnt    (vec_gnt),
		.con_gnt    (con_gnt),
		.cmd        (cmd),
		.tag        (tag)
	);

	bank_array u_bank_array (
		.clk_buf (clk_buf),
		.cmd     (cmd),
		.rdata   (bank_rdata)
	);

	// Load side
	load_align u_load_align (
		.tag           (tag),
		.rdata         (bank_rdata),
		.scalar_rdata  (scalar_rdata),
		.scalar_rvalid (scalar_rvalid),
		.vec_rdata     (vec_rdata),
		.vec_rvalid    (vec_rvalid),
		.con_rdata     (con_rdata),
		.con_rvalid    (con_rvalid)
	);

endmodule

//--- include/dmem_model.svh
// Reference memory for the testbench, one word per word address
// Included in the testbench module body after the package import
`ifndef DMEM_MODEL_SVH
`define DMEM_MODEL_SVH

logic [WORD_WIDTH-1:0] model_mem [1 << WORD_ADDR_BITS];  // Updated on every accepted write

// Fill value, differs in every address bit
function automatic logic [31:0] fill_word(logic [WORD_ADDR_BITS-1:0] w);
	return {6'h2b, w, 6'h15, ~w};
endfunction

// Controller style write, bytes picked by strobes
function automatic void merge_word(logic [WORD_ADDR_BITS-1:0] w, logic [3:0] strb,
		logic [31:0] d);
	for (int k = 0; k < 4; k++)
		if (strb[k])
			model_mem[w][8*k +: 8] = d[8*k +: 8];
endfunction

// Scalar SB/SH/SW merged byte by byte
function automatic void apply_store(scalar_req_t r);
	logic [WORD_ADDR_BITS-1:0] w;
	w = r.addr[BYTE_ADDR_BITS-1:2];
	for (int k = 0; k < 4; k++) begin
		if (r.store_sel == ST_WORD)
			model_mem[w][8*k +: 8] = r.wdata[8*k +: 8];
		else if (r.store_sel == ST_HALF && k / 2 == int'(r.addr[1]))
			model_mem[w][8*k +: 8] = r.wdata[8*(k%2) +: 8];  // Low half of the value
		else if (r.store_sel == ST_BYTE && k == int'(r.addr[1:0]))
			model_mem[w][8*k +: 8] = r.wdata[7:0];
	end
endfunction

// Expected load result, taken at acceptance time
function automatic logic [31:0] expect_load(scalar_req_t r);
	logic [31:0] word;
	logic [7:0]  b;
	logic [15:0] h;
	word = model_mem[r.addr[BYTE_ADDR_BITS-1:2]];
	b    = 8'(word >> (8 * int'(r.addr[1:0])));
	h    = 16'(word >> (16 * int'(r.addr[1])));  // Half picked by bit 1 only
	case (r.load_sel)
		LD_B:    return {{24{b[7]}}, b};
		LD_BU:   return {24'h0, b};
		LD_H:    return {{16{h[15]}}, h};
		LD_HU:   return {16'h0, h};
		default: return word;
	endcase
endfunction

`endif

//--- dv/dmem_tb.sv
// Testbench for the shared data memory with directed and random traffic on all three peers
// Concurrent assertions compare every read return and every grant with the reference model
`timescale 1ns/1ps

module dmem_tb;
	import dmem_pkg::*;

	localparam int N_DIRECTED = 600;   // Bank fill plus directed cases in cycles
	localparam int N_RANDOM   = 2000;

	logic        clk_buf = 1'b0;
	logic        arst_n  = 1'b0;
	scalar_req_t sreq    = '0;
	vector_req_t vreq    = '0;
	con_req_t    creq    = '0;
	logic        vec_gnt, con_gnt;
	logic        scalar_rvalid, vec_rvalid, con_rvalid;
	logic [WORD_WIDTH-1:0] scalar_rdata, con_rdata;
	lane_data_t  vec_rdata;

	integer      seed   = 32'ha25e_de9c;
	int          errors = 0;
	logic        s_pend = 1'b0;      // Reads accepted at the last edge
	logic        c_pend = 1'b0;
	logic        v_pend = 1'b0;
	logic [WORD_WIDTH-1:0] exp_s, exp_c;
	lane_data_t  exp_v;
	logic        vec_wins;           // Vector request with no scalar in the way
	logic        con_clash;          // Scalar sits on the controller's bank
	load_sel_e   ld_kinds [5] = '{LD_B, LD_H, LD_W, LD_BU, LD_HU};

	`include "dmem_model.svh"

	always #5 clk_buf = ~clk_buf;

	dmem_top dut0 (.*);

	//////////////////////////////////////////////////
	// Acceptance monitor, model and expectations
	//////////////////////////////////////////////////
	always @(posedge clk_buf) begin
		s_pend <= sreq.valid && !sreq.is_store;   // Scalar never waits
		c_pend <= creq.valid && con_gnt && (creq.strb == '0);
		v_pend <= vreq.valid && vec_gnt && !vreq.is_store;
		exp_s  <= expect_load(sreq);
		exp_c  <= model_mem[creq.addr];
		for (int i = 0; i < NUM_BANKS; i++)
			exp_v[i] <= model_mem[{vreq.row[i], 2'(i)}];  // Lane i on bank i
		// Writes after the reads of the same edge
		if (sreq.valid && sreq.is_store)
			apply_store(sreq);
		if (creq.valid && con_gnt)
			merge_word(creq.addr, creq.strb, creq.wdata);
		if (vreq.valid && vec_gnt && vreq.is_store)
			for (int i = 0; i < NUM_BANKS; i++)
				model_mem[{vreq.row[i], 2'(i)}] = vreq.wdata[i];
	end

	function automatic void mismatch(string sig, logic [127:0] exp, logic [127:0] got);
		errors++;
		$display("ERROR t=%0t %s expected %0h actual %0h", $time, sig, exp, got);
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	assign vec_wins  = vreq.valid && !sreq.valid;
	assign con_clash = sreq.valid && (sreq.addr[3:2] == creq.addr[1:0]);

	a_srv: assert property (@(posedge clk_buf) disable iff (!arst_n) scalar_rvalid == s_pend)
		else mismatch("scalar_rvalid", 128'($sampled(s_pend)), 128'($sampled(scalar_rvalid)));
	a_crv: assert property (@(posedge clk_buf) disable iff (!arst_n) con_rvalid == c_pend)
		else mismatch("con_rvalid", 128'($sampled(c_pend)), 128'($sampled(con_rvalid)));
	a_vrv: assert property (@(posedge clk_buf) disable iff (!arst_n) vec_rvalid == v_pend)
		else mismatch("vec_rvalid", 128'($sampled(v_pend)), 128'($sampled(vec_rvalid)));
	a_sd: assert property (@(posedge clk_buf) scalar_rvalid |-> scalar_rdata == exp_s)
		else mismatch("scalar_rdata", 128'($sampled(exp_s)), 128'($sampled(scalar_rdata)));
	a_cd: assert property (@(posedge clk_buf) con_rvalid |-> con_rdata == exp_c)
		else mismatch("con_rdata", 128'($sampled(exp_c)), 128'($sampled(con_rdata)));
	a_vd: assert property (@(posedge clk_buf) vec_rvalid |-> vec_rdata == exp_v)
		else mismatch("vec_rdata", 128'($sampled(exp_v)), 128'($sampled(vec_rdata)));
	// Vector needs all banks and yields to any scalar
	a_vg: assert property (@(posedge clk_buf) vec_gnt == vec_wins)
		else mismatch("vec_gnt", 128'($sampled(vec_wins)), 128'($sampled(vec_gnt)));
	// Controller yields to vector and to a scalar on its bank
	a_cg: assert property (@(posedge clk_buf)
			con_gnt == (creq.valid && !vec_wins && !con_clash))
		else mismatch("con_gnt", 128'(!$sampled(con_gnt)), 128'($sampled(con_gnt)));

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	function automatic scalar_req_t make_scalar(logic st, store_sel_e ss, load_sel_e ls,
			logic [BYTE_ADDR_BITS-1:0] a, logic [31:0] d);
		return '{valid: 1'b1, is_store: st, store_sel: ss, load_sel: ls, addr: a, wdata: d};
	endfunction

	task automatic scalar_access(scalar_req_t r, int hold);
		@(posedge clk_buf);
		sreq <= r;
		repeat (hold) @(posedge clk_buf);
		sreq <= '0;
	endtask

	task automatic con_access(logic [3:0] st, logic [WORD_ADDR_BITS-1:0] a, logic [31:0] d);
		@(posedge clk_buf);
		creq <= '{valid: 1'b1, strb: st, addr: a, wdata: d};
		@(posedge clk_buf);
		while (!con_gnt)
			@(posedge clk_buf);   // Held unchanged until granted
		creq <= '0;
	endtask

	task automatic vec_access(logic st, logic [NUM_BANKS-1:0][ROW_BITS-1:0] rows,
			lane_data_t d);
		@(posedge clk_buf);
		vreq <= '{valid: 1'b1, is_store: st, row: rows, wdata: d};
		@(posedge clk_buf);
		while (!vec_gnt)
			@(posedge clk_buf);
		vreq <= '0;
	endtask

	task automatic fill_banks();
		lane_data_t d;
		for (int r = 0; r < BANK_DEPTH; r++) begin
			for (int i = 0; i < NUM_BANKS; i++)
				d[i] = fill_word({8'(r), 2'(i)});
			vec_access(1'b1, {4{8'(r)}}, d);
		end
	endtask

	task automatic random_traffic(int n);
		logic [31:0] rnd;
		scalar_req_t s;
		vector_req_t v;
		for (int k = 0; k < n; k++) begin
			@(posedge clk_buf);
			rnd = $random(seed);
			s = make_scalar(rnd[1], rnd[3] ? ST_WORD : (rnd[2] ? ST_HALF : ST_BYTE),
				ld_kinds[int'(rnd[6:4]) % 5], rnd[19:8], $random(seed));
			s.valid = rnd[0];
			sreq <= s;
			if (!creq.valid || con_gnt)   // Previous one done
				creq <= '{valid: rnd[7], strb: rnd[20] ? rnd[24:21] : 4'h0,
					addr: 10'($random(seed)), wdata: $random(seed)};
			if (!vreq.valid || vec_gnt) begin
				v.valid    = rnd[25] & rnd[26];  // Rare since it stalls the controller
				v.is_store = rnd[27];
				for (int i = 0; i < NUM_BANKS; i++) begin
					v.row[i]   = 8'($random(seed));
					v.wdata[i] = $random(seed);
				end
				vreq <= v;
			end
		end
		// Scalar stops and held requests drain
		repeat (4) begin
			@(posedge clk_buf);
			sreq <= '0;
			if (vec_gnt)
				vreq <= '0;
			if (con_gnt)
				creq <= '0;
		end
	endtask

	initial begin
		repeat (10) @(posedge clk_buf);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk_buf);   // Idle with nothing granted or returned
		fill_banks();
		// Store merge then every load kind
		scalar_access(make_scalar(1'b1, ST_WORD, LD_W, 12'h100, 32'h1122_3344), 1);
		scalar_access(make_scalar(1'b1, ST_HALF, LD_W, 12'h103, 32'h0000_beef), 1);
		scalar_access(make_scalar(1'b1, ST_BYTE, LD_W, 12'h101, 32'h0000_0080), 1);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_B, 12'h101, '0), 1);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_BU, 12'h101, '0), 1);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_H, 12'h102, '0), 1);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_HU, 12'h103, '0), 1);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_W, 12'h102, '0), 1);
		// Interleave from controller to scalar and from vector to controller
		con_access(4'hf, 10'h2d7, 32'hc0de_0001);
		scalar_access(make_scalar(1'b0, ST_WORD, LD_W, 12'hb5c, '0), 1);
		vec_access(1'b1, {8'h24, 8'h23, 8'h22, 8'h21}, {32'ha3, 32'ha2, 32'ha1, 32'ha0});
		con_access(4'h0, 10'h08e, '0);                // Row 0x23 on lane 2
		con_access(4'b0100, 10'h08e, 32'h0055_0000);
		con_access(4'h0, 10'h08e, '0);
		// Same cycle on another bank and then on the same bank
		fork
			scalar_access(make_scalar(1'b0, ST_WORD, LD_H, 12'h016, '0), 1);
			con_access(4'h0, 10'h002, '0);
		join
		fork
			scalar_access(make_scalar(1'b0, ST_WORD, LD_BU, 12'h019, '0), 4);
			con_access(4'h0, 10'h006, '0);            // Waits for the scalar to leave
		join
		// Scalar blocks vector and vector blocks controller
		fork
			scalar_access(make_scalar(1'b0, ST_WORD, LD_W, 12'h200, '0), 3);
			vec_access(1'b0, {8'h24, 8'h23, 8'h22, 8'h21}, '0);
		join
		fork
			vec_access(1'b0, {8'hff, 8'h80, 8'h01, 8'h00}, '0);
			con_access(4'h0, 10'h3ff, '0);
		join
		random_traffic(N_RANDOM);
		repeat (3) @(posedge clk_buf);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial begin
		repeat ((N_DIRECTED + N_RANDOM) * 20) @(posedge clk_buf);
		$display("Timeout: the run did not reach its end in time");
		$display("Errors: %0d", errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- dmem.f
+incdir+include
rtl/dmem_pkg.sv
rtl/store_align.sv
rtl/mem_arbiter.sv
rtl/bank_array.sv
rtl/load_align.sv
rtl/dmem_top.sv
dv/dmem_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the data-memory testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dmem_tb -f dmem.f -o dmem_sim
./obj_dir/dmem_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: no errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
